// File: src/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Datapath width for PCs and instruction words
`define FETCH_WIDTH 16

// First fetch address out of reset
`define RESET_PC 16'h0000

// Predictor tables are direct mapped on the low PC bits
`define BHT_ENTRIES 16
`define BHT_INDEX_BITS 4

`endif

// File: src/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    // Word address, addresses count instructions
    typedef logic [`FETCH_WIDTH-1:0] addr_t;

    // Raw instruction word from instruction memory
    typedef logic [`FETCH_WIDTH-1:0] inst_t;

endpackage

// File: src/predict_pkg.sv
`include "fetch_defines.svh"

package predict_pkg;

    // 2-bit saturating counter, upper bit is the taken decision
    typedef enum logic [1:0] {
        STRONG_NT = 2'd0,
        WEAK_NT   = 2'd1,
        WEAK_T    = 2'd2,
        STRONG_T  = 2'd3
    } counter_e;

    // Low PC bits select the table entry
    typedef logic [`BHT_INDEX_BITS-1:0] bht_index_t;

    // Remaining upper PC bits, kept in the target buffer
    typedef logic [`FETCH_WIDTH-`BHT_INDEX_BITS-1:0] btb_tag_t;

endpackage

// File: src/pc_gen.sv
`include "fetch_defines.svh"

module pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             pred_taken,
    input  fetch_pkg::addr_t pred_target,
    output fetch_pkg::addr_t pc,
    output fetch_pkg::addr_t pc_next
);

    fetch_pkg::addr_t pc_seq;

    assign pc_seq = pc + 1'b1;

    // Predicted next PC, ignores redirect and stall
    always_comb begin
        if (pred_taken) begin
            pc_next = pred_target;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc; // Execute stage wins over everything
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // Stall without redirect freezes the fetch address
    property p_stall_holds_pc;
        @(posedge clk) disable iff (rst)
        (stall && !redirect_valid) |=> (pc == $past(pc));
    endproperty

    a_stall_holds_pc: assert property (p_stall_holds_pc)
        else $error("PC moved during stall");

endmodule

// File: src/branch_predictor.sv
`include "fetch_defines.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t pc,
    output logic             pred_taken,
    output logic [1:0]       prediction,
    output fetch_pkg::addr_t pred_target,
    input  logic             resolve_valid,
    input  fetch_pkg::addr_t resolve_pc,
    input  logic             resolve_taken,
    input  fetch_pkg::addr_t resolve_target
);

    // Branch history table
    predict_pkg::counter_e bht [`BHT_ENTRIES];

    // Direct-mapped target buffer
    logic [`BHT_ENTRIES-1:0] btb_valid;
    predict_pkg::btb_tag_t   btb_tag    [`BHT_ENTRIES];
    fetch_pkg::addr_t        btb_target [`BHT_ENTRIES];

    predict_pkg::bht_index_t lk_idx;
    predict_pkg::btb_tag_t   lk_tag;
    logic [1:0]              lk_cnt;
    logic                    lk_hit;

    predict_pkg::bht_index_t upd_idx;
    predict_pkg::btb_tag_t   upd_tag;
    predict_pkg::counter_e   upd_cnt;

    // Lookup side
    assign lk_idx = pc[`BHT_INDEX_BITS-1:0];
    assign lk_tag = pc[`FETCH_WIDTH-1:`BHT_INDEX_BITS];
    assign lk_cnt = bht[lk_idx];
    assign lk_hit = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag);

    assign prediction  = lk_cnt;
    assign pred_taken  = lk_cnt[1] && lk_hit; // Needs both direction and target
    assign pred_target = pred_taken ? btb_target[lk_idx] : pc + 1'b1;

    // Update side
    assign upd_idx = resolve_pc[`BHT_INDEX_BITS-1:0];
    assign upd_tag = resolve_pc[`FETCH_WIDTH-1:`BHT_INDEX_BITS];

    // Saturating step
    always_comb begin
        case (bht[upd_idx])
            predict_pkg::STRONG_NT: begin
                upd_cnt = resolve_taken ? predict_pkg::WEAK_NT : predict_pkg::STRONG_NT;
            end
            predict_pkg::WEAK_NT: begin
                upd_cnt = resolve_taken ? predict_pkg::WEAK_T : predict_pkg::STRONG_NT;
            end
            predict_pkg::WEAK_T: begin
                upd_cnt = resolve_taken ? predict_pkg::STRONG_T : predict_pkg::WEAK_NT;
            end
            default: begin
                upd_cnt = resolve_taken ? predict_pkg::STRONG_T : predict_pkg::WEAK_T;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                bht[i] <= predict_pkg::WEAK_NT;
            end
            btb_valid <= '0;
        end else if (resolve_valid) begin
            bht[upd_idx] <= upd_cnt;
            if (resolve_taken) begin
                btb_valid[upd_idx] <= 1'b1; // Only taken branches allocate
            end
        end
    end

    // Tag and target payload
    always_ff @(posedge clk) begin
        if (resolve_valid && resolve_taken) begin
            btb_tag[upd_idx]    <= upd_tag;
            btb_target[upd_idx] <= resolve_target;
        end
    end

    a_resolve_known: assert property (
        @(posedge clk) disable iff (rst)
        resolve_valid |-> !$isunknown(resolve_taken)
    ) else $error("Unknown branch outcome on resolve");

endmodule

// File: src/if_id_reg.sv
module if_id_reg (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             flush,
    input  fetch_pkg::addr_t pc,
    input  fetch_pkg::addr_t pc_next,
    input  fetch_pkg::inst_t inst,
    input  logic [1:0]       prediction,
    input  fetch_pkg::addr_t pred_target,
    output logic             if_id_valid,
    output fetch_pkg::addr_t if_id_pc,
    output fetch_pkg::addr_t if_id_pc_next,
    output fetch_pkg::inst_t if_id_inst,
    output logic [1:0]       if_id_prediction,
    output fetch_pkg::addr_t if_id_predicted_target
);

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_valid            <= 1'b0;
            if_id_pc               <= '0;
            if_id_pc_next          <= '0;
            if_id_inst             <= '0;
            if_id_prediction       <= '0;
            if_id_predicted_target <= '0;
        end else if (flush) begin
            if_id_valid <= 1'b0; // Payload is don't care once invalid
        end else if (!stall) begin
            if_id_valid            <= 1'b1;
            if_id_pc               <= pc;
            if_id_pc_next          <= pc_next;
            if_id_inst             <= inst;
            if_id_prediction       <= prediction;
            if_id_predicted_target <= pred_target;
        end
        // Stall holds every field
    end

    // Flush must leave a bubble for decode
    property p_flush_bubble;
        @(posedge clk) disable iff (rst)
        flush |=> !if_id_valid;
    endproperty

    a_flush_bubble: assert property (p_flush_bubble)
        else $error("IF/ID valid after flush");

endmodule

// File: src/fetch_unit.sv
module fetch_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             resolve_valid,
    input  fetch_pkg::addr_t resolve_pc,
    input  logic             resolve_taken,
    input  fetch_pkg::addr_t resolve_target,
    output fetch_pkg::addr_t imem_addr,
    input  fetch_pkg::inst_t imem_data,
    output logic             if_id_valid,
    output fetch_pkg::addr_t if_id_pc,
    output fetch_pkg::addr_t if_id_pc_next,
    output fetch_pkg::inst_t if_id_inst,
    output logic [1:0]       if_id_prediction,
    output fetch_pkg::addr_t if_id_predicted_target
);

    fetch_pkg::addr_t pc;
    fetch_pkg::addr_t pc_next;
    fetch_pkg::addr_t pred_target;
    logic             pred_taken;
    logic [1:0]       prediction;

    assign imem_addr = pc; // Memory answers in the same cycle

    pc_gen i_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .pc             (pc),
        .pc_next        (pc_next)
    );

    branch_predictor i_branch_predictor (
        .clk            (clk),
        .rst            (rst),
        .pc             (pc),
        .pred_taken     (pred_taken),
        .prediction     (prediction),
        .pred_target    (pred_target),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target)
    );

    // Redirect doubles as the flush
    if_id_reg i_if_id_reg (
        .clk                    (clk),
        .rst                    (rst),
        .stall                  (stall),
        .flush                  (redirect_valid),
        .pc                     (pc),
        .pc_next                (pc_next),
        .inst                   (imem_data),
        .prediction             (prediction),
        .pred_target            (pred_target),
        .if_id_valid            (if_id_valid),
        .if_id_pc               (if_id_pc),
        .if_id_pc_next          (if_id_pc_next),
        .if_id_inst             (if_id_inst),
        .if_id_prediction       (if_id_prediction),
        .if_id_predicted_target (if_id_predicted_target)
    );

endmodule

// File: tb/tb_fetch_unit.sv
`include "fetch_defines.svh"

module tb_fetch_unit;

    localparam int NUM_VEC    = 31;
    localparam int FIELDS     = 12; // 7 inputs and 5 expected values per line
    localparam int CLK_PERIOD = 4;
    localparam int TIMEOUT    = (NUM_VEC + 2 + 10) * CLK_PERIOD;

    logic             clk;
    logic             rst;
    logic             stall;
    logic             redirect_valid;
    fetch_pkg::addr_t redirect_pc;
    logic             resolve_valid;
    fetch_pkg::addr_t resolve_pc;
    logic             resolve_taken;
    fetch_pkg::addr_t resolve_target;
    fetch_pkg::addr_t imem_addr;
    fetch_pkg::inst_t imem_data;
    logic             if_id_valid;
    fetch_pkg::addr_t if_id_pc;
    fetch_pkg::addr_t if_id_pc_next;
    fetch_pkg::inst_t if_id_inst;
    logic [1:0]       if_id_prediction;
    fetch_pkg::addr_t if_id_predicted_target;

    fetch_pkg::inst_t imem [256];
    logic [15:0]      vec_mem [NUM_VEC*FIELDS];
    logic [31:0]      lcg_state;
    fetch_pkg::addr_t addr_before; // imem_addr seen before the edge
    int               cur_vec;

    // Instruction memory answers in the same cycle
    assign imem_data = imem[imem_addr[7:0]];

    fetch_unit i_fetch_unit (
        .clk                    (clk),
        .rst                    (rst),
        .stall                  (stall),
        .redirect_valid         (redirect_valid),
        .redirect_pc            (redirect_pc),
        .resolve_valid          (resolve_valid),
        .resolve_pc             (resolve_pc),
        .resolve_taken          (resolve_taken),
        .resolve_target         (resolve_target),
        .imem_addr              (imem_addr),
        .imem_data              (imem_data),
        .if_id_valid            (if_id_valid),
        .if_id_pc               (if_id_pc),
        .if_id_pc_next          (if_id_pc_next),
        .if_id_inst             (if_id_inst),
        .if_id_prediction       (if_id_prediction),
        .if_id_predicted_target (if_id_predicted_target)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error: vector %0d %s got 0x%h expected 0x%h", cur_vec, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic apply_vector(input int idx);
        int b;
        b              = idx * FIELDS;
        addr_before    = imem_addr;
        stall          = vec_mem[b][0];
        redirect_valid = vec_mem[b+1][0];
        redirect_pc    = vec_mem[b+2];
        resolve_valid  = vec_mem[b+3][0];
        resolve_pc     = vec_mem[b+4];
        resolve_taken  = vec_mem[b+5][0];
        resolve_target = vec_mem[b+6];
    endtask

    task automatic check_vector(input int idx);
        int b;
        b = idx * FIELDS;
        check_value("if_id_valid", {15'b0, if_id_valid}, vec_mem[b+7]);
        if (redirect_valid) begin
            check_value("imem_addr", imem_addr, redirect_pc);
        end else if (stall) begin
            check_value("imem_addr", imem_addr, addr_before); // Frozen PC
        end
        // Payload only matters for a valid entry
        if (vec_mem[b+7][0]) begin
            check_value("if_id_pc", if_id_pc, vec_mem[b+8]);
            check_value("if_id_pc_next", if_id_pc_next, vec_mem[b+9]);
            check_value("if_id_inst", if_id_inst, imem[vec_mem[b+8][7:0]]);
            check_value("if_id_prediction", {14'b0, if_id_prediction}, vec_mem[b+10]);
            check_value("if_id_predicted_target", if_id_predicted_target, vec_mem[b+11]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst            = 1'b1;
        stall          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        addr_before    = '0;
        cur_vec        = 0;
        lcg_state      = 32'h3eabe00c;
        for (int i = 0; i < 256; i++) begin
            lcg_state = lcg_next(lcg_state);
            imem[i]   = lcg_state[31:16] ^ i[15:0]; // Mix in the address
        end
        $readmemh("tb/fetch_stimulus.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*FIELDS-1])) begin
            $display("Stimulus file is missing or has fewer lines than expected");
            $display("Test FAILED");
            $fatal(1, "Bad stimulus file");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("if_id_valid", {15'b0, if_id_valid}, 16'h0000);
        check_value("imem_addr", imem_addr, `RESET_PC);

        for (int i = 0; i < NUM_VEC; i++) begin
            if (i != 0) begin
                @(negedge clk);
            end
            cur_vec = i + 1;
            apply_vector(i);
            @(posedge clk);
            #1;
            check_vector(i);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: tb/fetch_stimulus.txt
// stall redirect_valid redirect_pc resolve_valid resolve_pc resolve_taken resolve_target
// expected: if_id_valid if_id_pc if_id_pc_next if_id_prediction if_id_predicted_target
// Sequential fetch from reset
0 0 0000 0 0000 0 0000  1 0000 0001 1 0001
0 0 0000 0 0000 0 0000  1 0001 0002 1 0002
0 0 0000 0 0000 0 0000  1 0002 0003 1 0003
// Two stall cycles hold everything
1 0 0000 0 0000 0 0000  1 0002 0003 1 0003
1 0 0000 0 0000 0 0000  1 0002 0003 1 0003
0 0 0000 0 0000 0 0000  1 0003 0004 1 0004
// Train branch at 0008 taken to 0020
0 0 0000 1 0008 1 0020  1 0004 0005 1 0005
0 0 0000 1 0008 1 0020  1 0005 0006 1 0006
0 0 0000 0 0000 0 0000  1 0006 0007 1 0007
0 0 0000 0 0000 0 0000  1 0007 0008 1 0008
0 0 0000 0 0000 0 0000  1 0008 0020 3 0020
0 0 0000 0 0000 0 0000  1 0020 0021 1 0021
// Redirect to 0040, payload ignored while invalid
0 1 0040 0 0000 0 0000  0 0000 0000 0 0000
0 0 0000 0 0000 0 0000  1 0040 0041 1 0041
0 0 0000 0 0000 0 0000  1 0041 0042 1 0042
// Untrain 0008 then fetch it again
0 0 0000 1 0008 0 0000  1 0042 0043 1 0043
0 0 0000 1 0008 0 0000  1 0043 0044 1 0044
0 1 0008 0 0000 0 0000  0 0000 0000 0 0000
0 0 0000 0 0000 0 0000  1 0008 0009 1 0009
0 0 0000 0 0000 0 0000  1 0009 000a 1 000a
// Retrain 0008, then alias 0018 on the same index
0 0 0000 1 0008 1 0020  1 000a 000b 1 000b
0 0 0000 1 0008 1 0020  1 000b 000c 1 000c
0 1 0018 0 0000 0 0000  0 0000 0000 0 0000
0 0 0000 0 0000 0 0000  1 0018 0019 3 0019
0 0 0000 0 0000 0 0000  1 0019 001a 1 001a
// Stall on a predicted branch, resolve during lookup
0 1 0008 0 0000 0 0000  0 0000 0000 0 0000
1 0 0000 0 0000 0 0000  0 0000 0000 0 0000
0 0 0000 1 0008 0 0000  1 0008 0020 3 0020
0 0 0000 0 0000 0 0000  1 0020 0021 1 0021
// Redirect beats stall
1 1 0030 0 0000 0 0000  0 0000 0000 0 0000
0 0 0000 0 0000 0 0000  1 0030 0031 1 0031

// File: sources.f
+incdir+src
src/fetch_pkg.sv
src/predict_pkg.sv
src/pc_gen.sv
src/branch_predictor.sv
src/if_id_reg.sv
src/fetch_unit.sv
tb/tb_fetch_unit.sv

// File: Bender.yml
package:
  name: fetch_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_pkg.sv
      - src/predict_pkg.sv
      - src/pc_gen.sv
      - src/branch_predictor.sv
      - src/if_id_reg.sv
      - src/fetch_unit.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_fetch_unit.sv
